//--- src/pkt_pkg.sv
`default_nettype none

package pkt_pkg;

    // Flit geometry
    localparam int DATA_WIDTH  = 512;
    localparam int EMPTY_WIDTH = 6;
    localparam int PKT_AWIDTH  = 16;
    localparam int FLIT_WIDTH  = 8;

    // Protocol field values
    localparam logic [15:0] PROT_ETH      = 16'h0800;
    localparam logic [3:0]  IP_V4         = 4'd4;
    localparam logic [3:0]  IP_IHL_BASE   = 4'd5;
    localparam logic [7:0]  PROT_TCP      = 8'd6;
    localparam logic [7:0]  PROT_UDP      = 8'd17;
    localparam logic [15:0] UDP_HDR_BYTES = 16'd8;

    // Header start positions, in frame bytes
    localparam int ETH_TYPE_BYTE = 12;
    localparam int IP_HDR_BYTE   = 14;
    localparam int L4_HDR_BYTE   = 34;

    // Frame byte 0 sits in the top byte lane of the flit
    function automatic int byte_msb(input int idx);
        return DATA_WIDTH - 1 - 8 * idx;
    endfunction

    typedef struct packed {
        logic [DATA_WIDTH-1:0]  data;
        logic                   sop;
        logic                   eop;
        logic [EMPTY_WIDTH-1:0] empty;
    } pkt_flit_t;

    typedef struct packed {
        logic [31:0] sip;
        logic [31:0] dip;
        logic [15:0] sport;
        logic [15:0] dport;
    } tuple_t;

    typedef enum logic [1:0] {
        NS    = 2'd0,
        S_TCP = 2'd1,
        S_UDP = 2'd2
    } prot_t;

    typedef enum logic {
        PKT_ETH  = 1'b0,
        PKT_PCIE = 1'b1
    } pkt_flag_t;

    // Handed from ingress to parser along with the header flit
    typedef struct packed {
        logic [PKT_AWIDTH-1:0] pkt_id;
        logic [FLIT_WIDTH-1:0] flits;
    } ingress_meta_t;

    typedef struct packed {
        logic [PKT_AWIDTH-1:0] pkt_id;
        logic [FLIT_WIDTH-1:0] flits;
        logic [15:0]           len;
        tuple_t                tuple;
        prot_t                 prot;
        logic [8:0]            tcp_flags;
        pkt_flag_t             pkt_flags;
    } metadata_t;

endpackage

`default_nettype wire

//--- src/pkt_ingress.sv
`default_nettype none

module pkt_ingress (
    input  wire                        clk,
    input  wire                        rst,
    input  wire pkt_pkg::pkt_flit_t    in_flit,
    input  wire                        in_valid,
    output logic                       in_ready,
    output pkt_pkg::pkt_flit_t         hdr_flit,
    output pkt_pkg::ingress_meta_t     hdr_meta,
    output logic                       out_valid,
    input  wire                        out_ready
);

    logic                             in_frame;
    logic [pkt_pkg::FLIT_WIDTH-1:0]   flit_cnt;
    logic [pkt_pkg::PKT_AWIDTH-1:0]   next_id;
    pkt_pkg::pkt_flit_t               first_flit;
    pkt_pkg::pkt_flit_t               hdr_src;
    logic [pkt_pkg::FLIT_WIDTH-1:0]   cnt_now;
    logic                             accept;

    // Stall only while a finished header is still waiting downstream
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    // A single-flit frame is its own header
    always_comb begin
        hdr_src     = in_flit.sop ? in_flit : first_flit;
        hdr_src.sop = 1'b1;
        hdr_src.eop = 1'b1;
        cnt_now     = in_flit.sop ? pkt_pkg::FLIT_WIDTH'(1) : flit_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame  <= 1'b0;
            flit_cnt  <= '0;
            next_id   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (accept) begin
                flit_cnt <= cnt_now;
                in_frame <= !in_flit.eop;
                if (in_flit.eop) begin
                    out_valid <= 1'b1;
                    next_id   <= next_id + 1'b1;
                end
            end
        end
    end

    // Header and meta registers
    always_ff @(posedge clk) begin
        if (accept && in_flit.sop) begin
            first_flit <= in_flit;
        end
        if (accept && in_flit.eop) begin
            hdr_flit        <= hdr_src;
            hdr_meta.pkt_id <= next_id;
            hdr_meta.flits  <= cnt_now;
        end
    end

    // A new frame may only start once the previous one has seen its eop
    a_no_sop_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        (accept && in_frame) |-> !in_flit.sop
    );

endmodule

`default_nettype wire

//--- src/parser.sv
`default_nettype none

module parser (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          disable_pcie,
    input  wire pkt_pkg::pkt_flit_t      hdr_flit,
    input  wire pkt_pkg::ingress_meta_t  hdr_meta,
    input  wire                          in_valid,
    output logic                         in_ready,
    output pkt_pkg::metadata_t           out_meta,
    output logic                         out_valid,
    input  wire                          out_ready
);

    // Field positions in the header flit
    localparam int ETYPE_MSB = pkt_pkg::byte_msb(pkt_pkg::ETH_TYPE_BYTE);
    localparam int VER_MSB   = pkt_pkg::byte_msb(pkt_pkg::IP_HDR_BYTE);
    localparam int IHL_MSB   = VER_MSB - 4;
    localparam int TLEN_MSB  = pkt_pkg::byte_msb(pkt_pkg::IP_HDR_BYTE + 2);
    localparam int PROT_MSB  = pkt_pkg::byte_msb(pkt_pkg::IP_HDR_BYTE + 9);
    localparam int SIP_MSB   = pkt_pkg::byte_msb(pkt_pkg::IP_HDR_BYTE + 12);
    localparam int DIP_MSB   = pkt_pkg::byte_msb(pkt_pkg::IP_HDR_BYTE + 16);
    localparam int SPORT_MSB = pkt_pkg::byte_msb(pkt_pkg::L4_HDR_BYTE);
    localparam int DPORT_MSB = pkt_pkg::byte_msb(pkt_pkg::L4_HDR_BYTE + 2);
    localparam int DOFF_MSB  = pkt_pkg::byte_msb(pkt_pkg::L4_HDR_BYTE + 12);
    // NS bit is the low bit of the data offset byte, then the 8 flag bits
    localparam int FLAGS_MSB = DOFF_MSB - 7;

    logic [15:0]         eth_type;
    logic [3:0]          ip_ver;
    logic [3:0]          ip_ihl;
    logic [15:0]         ip_len;
    logic [7:0]          ip_prot;
    logic [31:0]         ip_sip;
    logic [31:0]         ip_dip;
    logic [15:0]         l4_sport;
    logic [15:0]         l4_dport;
    logic [3:0]          tcp_doff;
    logic [8:0]          tcp_flags;
    logic                is_tcp;
    logic                support;
    logic [15:0]         ihl_bytes;
    logic [15:0]         l4_bytes;
    pkt_pkg::metadata_t  meta_next;
    logic                accept;

    assign eth_type  = hdr_flit.data[ETYPE_MSB -: 16];
    assign ip_ver    = hdr_flit.data[VER_MSB -: 4];
    assign ip_ihl    = hdr_flit.data[IHL_MSB -: 4];
    assign ip_len    = hdr_flit.data[TLEN_MSB -: 16];
    assign ip_prot   = hdr_flit.data[PROT_MSB -: 8];
    assign ip_sip    = hdr_flit.data[SIP_MSB -: 32];
    assign ip_dip    = hdr_flit.data[DIP_MSB -: 32];
    assign l4_sport  = hdr_flit.data[SPORT_MSB -: 16];
    assign l4_dport  = hdr_flit.data[DPORT_MSB -: 16];
    assign tcp_doff  = hdr_flit.data[DOFF_MSB -: 4];
    assign tcp_flags = hdr_flit.data[FLAGS_MSB -: 9];

    assign is_tcp  = (ip_prot == pkt_pkg::PROT_TCP);
    // Only the fixed 20-byte IPv4 header is handled
    assign support = (eth_type == pkt_pkg::PROT_ETH)
                  && (ip_ver == pkt_pkg::IP_V4)
                  && (ip_ihl == pkt_pkg::IP_IHL_BASE)
                  && (is_tcp || (ip_prot == pkt_pkg::PROT_UDP));

    // Header lengths in bytes, from 32-bit word counts
    assign ihl_bytes = {10'd0, ip_ihl, 2'b00};
    assign l4_bytes  = is_tcp ? {10'd0, tcp_doff, 2'b00} : pkt_pkg::UDP_HDR_BYTES;

    always_comb begin
        meta_next.pkt_id      = hdr_meta.pkt_id;
        meta_next.flits       = hdr_meta.flits;
        meta_next.len         = ip_len - ihl_bytes - l4_bytes;
        meta_next.tuple.sip   = ip_sip;
        meta_next.tuple.dip   = ip_dip;
        meta_next.tuple.sport = l4_sport;
        meta_next.tuple.dport = l4_dport;
        meta_next.tcp_flags   = tcp_flags;
        meta_next.pkt_flags   = disable_pcie ? pkt_pkg::PKT_ETH : pkt_pkg::PKT_PCIE;
        if (!support) begin
            meta_next.prot = pkt_pkg::NS;
        end else if (is_tcp) begin
            meta_next.prot = pkt_pkg::S_TCP;
        end else begin
            meta_next.prot = pkt_pkg::S_UDP;
        end
    end

    // Output register takes a new record when empty or draining
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_meta <= meta_next;
        end
    end

    // Stalled record must be held until the FIFO takes it
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_meta))
    );

    // Ingress always presents the header as a complete frame
    a_single_flit_hdr: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> (hdr_flit.sop && hdr_flit.eop)
    );

endmodule

`default_nettype wire

//--- src/meta_fifo.sv
`default_nettype none

module meta_fifo #(
    parameter int DEPTH = 4
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire pkt_pkg::metadata_t  in_meta,
    input  wire                      in_valid,
    output logic                     in_ready,
    output pkt_pkg::metadata_t       out_meta,
    output logic                     out_valid,
    input  wire                      out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    pkt_pkg::metadata_t  mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                push;
    logic                pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    // Head entry comes straight from the storage flops
    assign out_meta  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_meta;
        end
    end

    // Full FIFO never grows past its depth
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        (count == CNT_W'(DEPTH)) |=> (count <= CNT_W'(DEPTH))
    );

    // Empty FIFO never underflows and wraps the count
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        (count == '0) |=> (count <= CNT_W'(1))
    );

endmodule

`default_nettype wire

//--- src/header_parse_top.sv
`default_nettype none

module header_parse_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      disable_pcie,
    input  wire pkt_pkg::pkt_flit_t  in_flit,
    input  wire                      in_valid,
    output logic                     in_ready,
    output pkt_pkg::metadata_t       out_meta,
    output logic                     out_valid,
    input  wire                      out_ready
);

    // Ingress to parser
    pkt_pkg::pkt_flit_t      ing_hdr_flit;
    pkt_pkg::ingress_meta_t  ing_hdr_meta;
    logic                    ing_valid;
    logic                    ing_ready;

    // Parser to FIFO
    pkt_pkg::metadata_t      prs_meta;
    logic                    prs_valid;
    logic                    prs_ready;

    pkt_ingress ingress_i (
        .clk       (clk),
        .rst       (rst),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .hdr_flit  (ing_hdr_flit),
        .hdr_meta  (ing_hdr_meta),
        .out_valid (ing_valid),
        .out_ready (ing_ready)
    );

    parser parser_i (
        .clk          (clk),
        .rst          (rst),
        .disable_pcie (disable_pcie),
        .hdr_flit     (ing_hdr_flit),
        .hdr_meta     (ing_hdr_meta),
        .in_valid     (ing_valid),
        .in_ready     (ing_ready),
        .out_meta     (prs_meta),
        .out_valid    (prs_valid),
        .out_ready    (prs_ready)
    );

    meta_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_meta   (prs_meta),
        .in_valid  (prs_valid),
        .in_ready  (prs_ready),
        .out_meta  (out_meta),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- test/header_parse_checker.sv
`default_nettype none

module header_parse_checker (
    input  wire                      clk,
    input  wire                      rst,
    input  wire pkt_pkg::metadata_t  out_meta,
    input  wire                      out_valid,
    input  wire                      out_ready,
    input  wire                      in_ready,
    input  wire                      exp_push,
    input  wire pkt_pkg::metadata_t  exp_meta,
    input  wire [127:0]              exp_name,
    output int                       pass_count,
    output int                       fail_count,
    output int                       pending
);

    pkt_pkg::metadata_t  exp_q [$];
    logic [127:0]        name_q [$];
    pkt_pkg::metadata_t  head_meta;
    logic [127:0]        head_name;
    logic                idle_check;

    initial begin
        pass_count = 0;
        fail_count = 0;
        pending    = 0;
        idle_check = 1'b0;
    end

    // Sample between edges, where DUT outputs and driven inputs are settled
    always @(negedge clk) begin
        // First cycle out of reset: nothing buffered, input side open
        if (rst) begin
            idle_check = 1'b1;
        end else if (idle_check) begin
            idle_check = 1'b0;
            if (in_ready === 1'b1 && out_valid === 1'b0) begin
                $display("PASS reset_state");
                pass_count = pass_count + 1;
            end else begin
                $display("FAIL reset_state expected in_ready 1 out_valid 0 actual %b %b",
                         in_ready, out_valid);
                fail_count = fail_count + 1;
            end
        end
        if (exp_push) begin
            exp_q.push_back(exp_meta);
            name_q.push_back(exp_name);
        end
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: output record %h arrived with no expected record queued",
                         out_meta);
                fail_count = fail_count + 1;
            end else begin
                head_meta = exp_q.pop_front();
                head_name = name_q.pop_front();
                if (out_meta === head_meta) begin
                    $display("PASS %0s", head_name);
                    pass_count = pass_count + 1;
                end else begin
                    $display("FAIL %0s expected %h actual %h", head_name, head_meta, out_meta);
                    fail_count = fail_count + 1;
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

//--- test/header_parse_tb.sv
`default_nettype none

module header_parse_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int MAX_ENTRIES = 16;
    // Entries from this index on see a random out_ready
    localparam int RAND_FROM   = 6;

    logic                 clk;
    logic                 rst;
    logic                 disable_pcie;
    pkt_pkg::pkt_flit_t   in_flit;
    logic                 in_valid;
    logic                 in_ready;
    pkt_pkg::metadata_t   out_meta;
    logic                 out_valid;
    logic                 out_ready;

    logic                 exp_push;
    pkt_pkg::metadata_t   exp_meta;
    logic [127:0]         exp_name;
    int                   pass_count;
    int                   fail_count;
    int                   pending;

    // Stimulus table
    logic [127:0]         tst_name  [MAX_ENTRIES];
    pkt_pkg::pkt_flit_t   tst_hdr   [MAX_ENTRIES];
    int                   tst_flits [MAX_ENTRIES];
    logic                 tst_dis   [MAX_ENTRIES];
    pkt_pkg::metadata_t   tst_exp   [MAX_ENTRIES];
    int                   num_entries;
    int                   total_flits;
    logic                 table_ready;

    logic [31:0]          seed;
    logic                 ready_pat [256];
    logic                 rand_ready;
    int                   ready_cycle;
    int                   i;

    header_parse_top #(
        .FIFO_DEPTH (4)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .disable_pcie (disable_pcie),
        .in_flit      (in_flit),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_meta     (out_meta),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    header_parse_checker checker_i (
        .clk        (clk),
        .rst        (rst),
        .out_meta   (out_meta),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .exp_push   (exp_push),
        .exp_meta   (exp_meta),
        .exp_name   (exp_name),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fill_random(output logic [511:0] d);
        int w;
        for (w = 0; w < 16; w++) begin
            d[32 * w +: 32] = $random(seed);
        end
    endtask

    // Builds one header flit and works out its record from the field rules
    task automatic add_entry(input logic [127:0] name, input logic [15:0] etype,
                             input logic [3:0] ihl, input logic [7:0] proto,
                             input logic [15:0] tlen, input logic [3:0] doff,
                             input int nflits, input logic dis);
        logic [511:0]        d;
        logic [31:0]         sip;
        logic [31:0]         dip;
        logic [31:0]         ports;
        logic [8:0]          flags;
        logic [15:0]         l4_len;
        logic                supported;
        pkt_pkg::metadata_t  e;
        fill_random(d);
        sip   = $random(seed);
        dip   = $random(seed);
        ports = $random(seed);
        flags = 9'($random(seed));
        // Byte n of the frame has its msb at bit 511 - 8n
        d[511 - 8 * 12 -: 16] = etype;
        d[511 - 8 * 14 -: 8]  = {4'd4, ihl};
        d[511 - 8 * 16 -: 16] = tlen;
        d[511 - 8 * 23 -: 8]  = proto;
        d[511 - 8 * 26 -: 32] = sip;
        d[511 - 8 * 30 -: 32] = dip;
        d[511 - 8 * 34 -: 32] = ports;
        d[511 - 8 * 46 -: 16] = {doff, 3'b000, flags};

        l4_len    = (proto == 8'd6) ? 16'(4 * doff) : 16'd8;
        supported = (etype == 16'h0800) && (ihl == 4'd5) && (proto == 8'd6 || proto == 8'd17);
        e.pkt_id          = 16'(num_entries);
        e.flits           = 8'(nflits);
        e.len             = tlen - 16'(4 * ihl) - l4_len;
        e.tuple.sip       = sip;
        e.tuple.dip       = dip;
        e.tuple.sport     = ports[31:16];
        e.tuple.dport     = ports[15:0];
        e.tcp_flags       = flags;
        e.pkt_flags       = dis ? pkt_pkg::PKT_ETH : pkt_pkg::PKT_PCIE;
        if (!supported) begin
            e.prot = pkt_pkg::NS;
        end else if (proto == 8'd6) begin
            e.prot = pkt_pkg::S_TCP;
        end else begin
            e.prot = pkt_pkg::S_UDP;
        end

        tst_name[num_entries]      = name;
        tst_hdr[num_entries].data  = d;
        tst_hdr[num_entries].sop   = 1'b1;
        tst_hdr[num_entries].eop   = (nflits == 1);
        tst_hdr[num_entries].empty = (nflits == 1) ? 6'd10 : 6'd0;
        tst_flits[num_entries]     = nflits;
        tst_dis[num_entries]       = dis;
        tst_exp[num_entries]       = e;
        num_entries                = num_entries + 1;
        total_flits                = total_flits + nflits;
    endtask

    task automatic build_table();
        int k;
        num_entries = 0;
        total_flits = 0;
        add_entry("tcp_single",    16'h0800, 4'd5, 8'd6,  16'd120, 4'd5, 1, 1'b0);
        add_entry("udp_single",    16'h0800, 4'd5, 8'd17, 16'd200, 4'd5, 1, 1'b0);
        add_entry("arp_ns",        16'h0806, 4'd5, 8'd6,  16'd60,  4'd5, 1, 1'b0);
        add_entry("ihl6_ns",       16'h0800, 4'd6, 8'd6,  16'd100, 4'd5, 1, 1'b0);
        add_entry("icmp_ns",       16'h0800, 4'd5, 8'd1,  16'd84,  4'd5, 1, 1'b0);
        add_entry("tcp_3flit",     16'h0800, 4'd5, 8'd6,  16'd180, 4'd8, 3, 1'b0);
        add_entry("udp_5flit",     16'h0800, 4'd5, 8'd17, 16'd300, 4'd5, 5, 1'b0);
        add_entry("tcp_eth_mode",  16'h0800, 4'd5, 8'd6,  16'd90,  4'd6, 1, 1'b1);
        add_entry("udp_eth_mode",  16'h0800, 4'd5, 8'd17, 16'd70,  4'd5, 2, 1'b1);
        add_entry("tcp_pcie_mode", 16'h0800, 4'd5, 8'd6,  16'd150, 4'd5, 1, 1'b0);
        // Back-to-back frames to fill the FIFO under random back-pressure
        add_entry("burst_tcp_a",   16'h0800, 4'd5, 8'd6,  16'd64,  4'd5, 1, 1'b0);
        add_entry("burst_udp_a",   16'h0800, 4'd5, 8'd17, 16'd72,  4'd5, 2, 1'b0);
        add_entry("burst_tcp_b",   16'h0800, 4'd5, 8'd6,  16'd500, 4'd15, 3, 1'b0);
        add_entry("burst_udp_b",   16'h0800, 4'd5, 8'd17, 16'd28,  4'd5, 1, 1'b0);
        add_entry("burst_arp",     16'h0806, 4'd5, 8'd17, 16'd46,  4'd5, 4, 1'b0);
        add_entry("burst_tcp_c",   16'h0800, 4'd5, 8'd6,  16'd1500, 4'd7, 1, 1'b0);
        for (k = 0; k < 256; k++) begin
            ready_pat[k] = $random(seed) & 1;
        end
    endtask

    // Holds the flit until a cycle in which in_ready is high
    task automatic send_flit(input pkt_pkg::pkt_flit_t f);
        logic done;
        in_flit  <= f;
        in_valid <= 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
        end
    endtask

    task automatic send_frame(input int idx);
        pkt_pkg::pkt_flit_t f;
        logic [511:0]       d;
        int                 k;
        f = tst_hdr[idx];
        for (k = 0; k < tst_flits[idx]; k++) begin
            if (k > 0) begin
                fill_random(d);
                f.data  = d;
                f.sop   = 1'b0;
                f.eop   = (k == tst_flits[idx] - 1);
                f.empty = f.eop ? 6'd20 : 6'd0;
            end
            send_flit(f);
        end
        in_valid <= 1'b0;
    endtask

    // Consumer side
    initial begin
        ready_cycle = 0;
        forever begin
            @(posedge clk);
            if (rand_ready) begin
                out_ready   <= ready_pat[ready_cycle % 256];
                ready_cycle = ready_cycle + 1;
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    initial begin
        wait (table_ready);
        #((total_flits + 10 * num_entries) * 4 * CLK_PERIOD);
        $display("ERROR: timeout, run did not finish with %0d records still pending", pending);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed         = 32'hd3fc_a94d;
        rst          = 1'b1;
        disable_pcie = 1'b0;
        in_flit      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        exp_push     = 1'b0;
        exp_meta     = '0;
        exp_name     = '0;
        rand_ready   = 1'b0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (i = 0; i < num_entries; i++) begin
            if (i >= RAND_FROM) begin
                rand_ready <= 1'b1;
            end
            // Mode may only change once every earlier frame has left the parser
            if (tst_dis[i] != disable_pcie) begin
                while (pending != 0) @(posedge clk);
            end
            disable_pcie <= tst_dis[i];
            exp_push     <= 1'b1;
            exp_meta     <= tst_exp[i];
            exp_name     <= tst_name[i];
            @(posedge clk);
            exp_push <= 1'b0;
            send_frame(i);
        end

        while (pending != 0) @(posedge clk);
        repeat (5) @(posedge clk);

        $display("Summary: %0d passed, %0d failed, %0d of %0d records unmatched",
                 pass_count, fail_count, pending, num_entries);
        // One pass per record plus the idle check after reset
        if (fail_count == 0 && pending == 0 && pass_count == num_entries + 1) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- header_parse_top.f
src/pkt_pkg.sv
src/pkt_ingress.sv
src/parser.sv
src/meta_fifo.sv
src/header_parse_top.sv
test/header_parse_checker.sv
test/header_parse_tb.sv

//--- Bender.yml
package:
  name: header_parse

sources:
  # Design
  - src/pkt_pkg.sv
  - src/pkt_ingress.sv
  - src/parser.sv
  - src/meta_fifo.sv
  - src/header_parse_top.sv

  # Testbench
  - target: test
    files:
      - test/header_parse_checker.sv
      - test/header_parse_tb.sv
